//--- common/ntw_pkg.sv
`default_nettype none

package ntw_pkg;

    localparam logic [7:0] PROTO_ICMP = 8'h01;
    localparam logic [7:0] PROTO_TCP  = 8'h06;
    localparam logic [7:0] PROTO_UDP  = 8'h11;

    localparam int TCP_IDX   = 0;
    localparam int UDP_IDX   = 1;
    localparam int ICMP_IDX  = 2;
    localparam int NUM_LANES = 3;

    localparam logic [7:0] REPLY_TTL = 8'd64;

    typedef struct packed {
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] length;
        logic [7:0]  ttl;
    } ip_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } pay_beat_t;

endpackage

`default_nettype wire

//--- ip_arb_mux/ip_arb_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ip_arb_mux (
    input  wire                           i_clk,
    input  wire                           i_rst,

    input  wire  [ntw_pkg::NUM_LANES-1:0] i_lane_hdr_valid,
    output logic [ntw_pkg::NUM_LANES-1:0] o_lane_hdr_ready,
    input  wire  [7:0]                    i_lane_protocol  [ntw_pkg::NUM_LANES],
    input  wire  [31:0]                   i_lane_source_ip [ntw_pkg::NUM_LANES],
    input  wire  [31:0]                   i_lane_dest_ip   [ntw_pkg::NUM_LANES],
    input  wire  [15:0]                   i_lane_length    [ntw_pkg::NUM_LANES],
    input  wire  [7:0]                    i_lane_ttl       [ntw_pkg::NUM_LANES],
    input  wire  [ntw_pkg::NUM_LANES-1:0] i_lane_pay_valid,
    output logic [ntw_pkg::NUM_LANES-1:0] o_lane_pay_ready,
    input  wire  [7:0]                    i_lane_pay_data  [ntw_pkg::NUM_LANES],
    input  wire  [ntw_pkg::NUM_LANES-1:0] i_lane_pay_last,

    output logic                          o_tx_hdr_valid,
    input  wire                           i_tx_hdr_ready,
    output logic [7:0]                    o_tx_protocol,
    output logic [31:0]                   o_tx_source_ip,
    output logic [31:0]                   o_tx_dest_ip,
    output logic [15:0]                   o_tx_length,
    output logic [7:0]                    o_tx_ttl,
    output logic                          o_tx_pay_valid,
    input  wire                           i_tx_pay_ready,
    output logic [7:0]                    o_tx_pay_data,
    output logic                          o_tx_pay_last
);

    import ntw_pkg::*;

    localparam int LW = $clog2(NUM_LANES);

    logic          locked;
    logic          hdr_done;   // header of the granted packet already sent
    logic [LW-1:0] grant;
    logic [LW-1:0] rr_ptr;
    logic          pick_found;
    logic [LW-1:0] pick_idx;
    int            cand;

    // first lane with a header, searching from the pointer
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        cand       = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_LANES;
            if (!pick_found && i_lane_hdr_valid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = LW'(cand);
            end
        end
    end

    assign o_tx_hdr_valid = locked && !hdr_done && i_lane_hdr_valid[grant];
    assign o_tx_protocol  = i_lane_protocol[grant];
    assign o_tx_source_ip = i_lane_source_ip[grant];
    assign o_tx_dest_ip   = i_lane_dest_ip[grant];
    assign o_tx_length    = i_lane_length[grant];
    assign o_tx_ttl       = i_lane_ttl[grant];
    assign o_tx_pay_valid = locked && hdr_done && i_lane_pay_valid[grant];
    assign o_tx_pay_data  = i_lane_pay_data[grant];
    assign o_tx_pay_last  = i_lane_pay_last[grant];

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            o_lane_hdr_ready[k] = locked && !hdr_done && (grant == LW'(k)) && i_tx_hdr_ready;
            o_lane_pay_ready[k] = locked && hdr_done && (grant == LW'(k)) && i_tx_pay_ready;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            locked   <= 1'b0;
            hdr_done <= 1'b0;
            grant    <= '0;
            rr_ptr   <= '0;
        end else if (!locked) begin
            if (pick_found) begin
                locked   <= 1'b1;
                hdr_done <= 1'b0;
                grant    <= pick_idx;
                rr_ptr   <= (pick_idx == LW'(NUM_LANES - 1)) ? '0 : pick_idx + 1'b1;
            end
        end else if (!hdr_done) begin
            if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                hdr_done <= 1'b1;
            end
        end else if (o_tx_pay_valid && i_tx_pay_ready && o_tx_pay_last) begin
            locked <= 1'b0;   // whole packet out, rearbitrate
        end
    end

endmodule

`default_nettype wire

//--- ip_demux/ip_demux.sv
`timescale 1ns/1ps
`default_nettype none

module ip_demux #(
    parameter logic [31:0] LOCAL_IP = 32'hac000002
)(
    input  wire                           i_clk,
    input  wire                           i_rst,

    input  wire                           i_rx_hdr_valid,
    output logic                          o_rx_hdr_ready,
    input  wire  [7:0]                    i_rx_protocol,
    input  wire  [31:0]                   i_rx_source_ip,
    input  wire  [31:0]                   i_rx_dest_ip,
    input  wire  [15:0]                   i_rx_length,
    input  wire  [7:0]                    i_rx_ttl,
    input  wire                           i_rx_pay_valid,
    output logic                          o_rx_pay_ready,
    input  wire  [7:0]                    i_rx_pay_data,
    input  wire                           i_rx_pay_last,

    output logic [ntw_pkg::NUM_LANES-1:0] o_lane_hdr_valid,
    input  wire  [ntw_pkg::NUM_LANES-1:0] i_lane_hdr_ready,
    output logic [7:0]                    o_lane_protocol  [ntw_pkg::NUM_LANES],
    output logic [31:0]                   o_lane_source_ip [ntw_pkg::NUM_LANES],
    output logic [15:0]                   o_lane_length    [ntw_pkg::NUM_LANES],
    output logic [ntw_pkg::NUM_LANES-1:0] o_lane_pay_valid,
    input  wire  [ntw_pkg::NUM_LANES-1:0] i_lane_pay_ready,
    output logic [7:0]                    o_lane_pay_data  [ntw_pkg::NUM_LANES],
    output logic [ntw_pkg::NUM_LANES-1:0] o_lane_pay_last
);

    import ntw_pkg::*;

    localparam int LW = $clog2(NUM_LANES);

    typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAY, ST_DROP} state_t;

    state_t        state;
    logic          rx_open;   // high from the cycle after the FSM is idle
    logic [LW-1:0] sel;
    logic [LW-1:0] rx_lane;
    logic          rx_known;
    logic          rx_keep;
    logic          pay_done;
    logic [7:0]    hdr_protocol;
    logic [31:0]   hdr_source_ip;
    logic [15:0]   hdr_length;

    always_comb begin
        rx_known = 1'b1;
        rx_lane  = '0;
        case (i_rx_protocol)
            PROTO_TCP:  rx_lane = LW'(TCP_IDX);
            PROTO_UDP:  rx_lane = LW'(UDP_IDX);
            PROTO_ICMP: rx_lane = LW'(ICMP_IDX);
            default:    rx_known = 1'b0;
        endcase
    end

    // ttl is ignored here as each lane sets a fresh one
    assign rx_keep        = rx_known && (i_rx_dest_ip == LOCAL_IP);
    assign o_rx_hdr_ready = rx_open;
    assign pay_done       = i_rx_pay_valid && o_rx_pay_ready && i_rx_pay_last;

    always_comb begin
        o_rx_pay_ready = (state == ST_DROP);   // dropped payload drains freely
        if (state == ST_PAY) begin
            o_rx_pay_ready = i_lane_pay_ready[sel];
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            o_lane_hdr_valid[k] = (state == ST_HDR) && (sel == LW'(k));
            o_lane_pay_valid[k] = (state == ST_PAY) && (sel == LW'(k)) && i_rx_pay_valid;
            o_lane_protocol[k]  = hdr_protocol;
            o_lane_source_ip[k] = hdr_source_ip;
            o_lane_length[k]    = hdr_length;
            o_lane_pay_data[k]  = i_rx_pay_data;
            o_lane_pay_last[k]  = i_rx_pay_last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_IDLE;
            sel     <= '0;
            rx_open <= 1'b0;
        end else begin
            rx_open <= (state == ST_IDLE) && !(o_rx_hdr_ready && i_rx_hdr_valid);
            case (state)
                ST_IDLE: begin
                    if (o_rx_hdr_ready && i_rx_hdr_valid) begin
                        sel   <= rx_lane;
                        state <= rx_keep ? ST_HDR : ST_DROP;
                    end
                end
                ST_HDR: begin
                    if (i_lane_hdr_ready[sel]) begin
                        state <= ST_PAY;
                    end
                end
                ST_PAY, ST_DROP: begin
                    if (pay_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_rx_hdr_ready && i_rx_hdr_valid) begin
            hdr_protocol  <= i_rx_protocol;
            hdr_source_ip <= i_rx_source_ip;
            hdr_length    <= i_rx_length;
        end
    end

endmodule

`default_nettype wire

//--- proto_lane/proto_lane.sv
`timescale 1ns/1ps
`default_nettype none

module proto_lane #(
    parameter logic [31:0] LOCAL_IP  = 32'hac000002,
    parameter int          HDR_DEPTH = 4,
    parameter int          PAY_DEPTH = 64
)(
    input  wire         i_clk,
    input  wire         i_rst,

    input  wire         i_hdr_valid,
    output logic        o_hdr_ready,
    input  wire  [7:0]  i_protocol,
    input  wire  [31:0] i_source_ip,
    input  wire  [15:0] i_length,
    input  wire         i_pay_valid,
    output logic        o_pay_ready,
    input  wire  [7:0]  i_pay_data,
    input  wire         i_pay_last,

    output logic        o_hdr_valid,
    input  wire         i_hdr_ready,
    output logic [7:0]  o_protocol,
    output logic [31:0] o_source_ip,
    output logic [31:0] o_dest_ip,
    output logic [15:0] o_length,
    output logic [7:0]  o_ttl,
    output logic        o_pay_valid,
    input  wire         i_pay_ready,
    output logic [7:0]  o_pay_data,
    output logic        o_pay_last
);

    import ntw_pkg::*;

    ip_hdr_t   wr_hdr;
    ip_hdr_t   rd_hdr;
    pay_beat_t wr_beat;
    pay_beat_t rd_beat;

    // reply record is built on the way in
    always_comb begin
        wr_hdr.protocol  = i_protocol;
        wr_hdr.source_ip = LOCAL_IP;
        wr_hdr.dest_ip   = i_source_ip;   // back to the sender
        wr_hdr.length    = i_length;
        wr_hdr.ttl       = REPLY_TTL;
        wr_beat.data     = i_pay_data;
        wr_beat.last     = i_pay_last;
    end

    sync_fifo #(
        .T     (ip_hdr_t),
        .DEPTH (HDR_DEPTH)
    ) u_hdr_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr_valid (i_hdr_valid),
        .o_wr_ready (o_hdr_ready),
        .i_wr_data  (wr_hdr),
        .o_rd_valid (o_hdr_valid),
        .i_rd_ready (i_hdr_ready),
        .o_rd_data  (rd_hdr)
    );

    sync_fifo #(
        .T     (pay_beat_t),
        .DEPTH (PAY_DEPTH)
    ) u_pay_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr_valid (i_pay_valid),
        .o_wr_ready (o_pay_ready),
        .i_wr_data  (wr_beat),
        .o_rd_valid (o_pay_valid),
        .i_rd_ready (i_pay_ready),
        .o_rd_data  (rd_beat)
    );

    assign o_protocol  = rd_hdr.protocol;
    assign o_source_ip = rd_hdr.source_ip;
    assign o_dest_ip   = rd_hdr.dest_ip;
    assign o_length    = rd_hdr.length;
    assign o_ttl       = rd_hdr.ttl;
    assign o_pay_data  = rd_beat.data;
    assign o_pay_last  = rd_beat.last;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module tb_ip_proto_switch \
    --Mdir obj_dir -o tb_ip_proto_switch

# exit status is nonzero when the run ends in $fatal
./obj_dir/tb_ip_proto_switch

//--- sim/tb_ip_proto_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ip_proto_switch;

    import ntw_pkg::*;

    localparam logic [31:0] LOCAL_IP   = 32'hac000002;
    localparam logic [31:0] FOREIGN_IP = 32'hac000099;
    localparam int          TIMEOUT    = 10000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        i_rx_hdr_valid;
    logic        o_rx_hdr_ready;
    logic        i_rx_pay_valid;
    logic        o_rx_pay_ready;
    logic [7:0]  i_rx_protocol;
    logic [7:0]  i_rx_ttl;
    logic [7:0]  i_rx_pay_data;
    logic [31:0] i_rx_source_ip;
    logic [31:0] i_rx_dest_ip;
    logic [15:0] i_rx_length;
    logic        i_rx_pay_last;
    logic        o_tx_hdr_valid;
    logic        o_tx_pay_valid;
    logic        o_tx_pay_last;
    logic        i_tx_hdr_ready = 1'b0;
    logic        i_tx_pay_ready = 1'b0;
    logic [7:0]  o_tx_protocol;
    logic [7:0]  o_tx_ttl;
    logic [7:0]  o_tx_pay_data;
    logic [31:0] o_tx_source_ip;
    logic [31:0] o_tx_dest_ip;
    logic [15:0] o_tx_length;
    logic        bp_on = 1'b0;

    ip_hdr_t     pkt [256];
    int          num_pkts;
    ip_hdr_t     exp_hdr_q [NUM_LANES][$];   // expected replies per lane
    logic [7:0]  exp_pay_q [NUM_LANES][$];

    ip_proto_switch #(.LOCAL_IP(LOCAL_IP), .HDR_DEPTH(4), .PAY_DEPTH(64)) uut (
        .i_clk (clk),
        .i_rst (rst),
        .*
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (bp_on) begin
            i_tx_hdr_ready <= ($urandom % 4 == 0);
            i_tx_pay_ready <= 1'($urandom);
        end else begin
            i_tx_hdr_ready <= 1'b1;
            i_tx_pay_ready <= 1'b1;
        end
    end

    function automatic int lane_of(logic [7:0] proto);
        case (proto)
            PROTO_TCP:  return TCP_IDX;
            PROTO_UDP:  return UDP_IDX;
            PROTO_ICMP: return ICMP_IDX;
            default:    return -1;
        endcase
    endfunction

    function automatic bit is_accepted(ip_hdr_t h);
        return (lane_of(h.protocol) >= 0) && (h.dest_ip == LOCAL_IP);
    endfunction

    // reference model of the echo reply
    function automatic ip_hdr_t reply_for(ip_hdr_t sent);
        ip_hdr_t r;
        r           = sent;
        r.source_ip = LOCAL_IP;
        r.dest_ip   = sent.source_ip;
        r.ttl       = REPLY_TTL;
        return r;
    endfunction

    function automatic ip_hdr_t make_hdr(logic [7:0] proto, logic [31:0] dest, int len);
        ip_hdr_t h;
        h.protocol  = proto;
        h.source_ip = 32'($urandom);
        h.dest_ip   = dest;
        h.length    = 16'(len);
        h.ttl       = 8'($urandom);
        return h;
    endfunction

    function automatic int pending();
        int sum;
        sum = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            sum += exp_hdr_q[k].size() + exp_pay_q[k].size();
        end
        return sum;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            abort_run($sformatf("[ERROR] %s expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic wait_step(inout int n, input string what);
        @(negedge clk);
        n++;
        if (n > TIMEOUT) begin
            abort_run({"timed out waiting for ", what});
        end
    endtask

    task automatic send_packet(input ip_hdr_t h);
        int         n;
        int         lane;
        logic [7:0] b;
        lane = lane_of(h.protocol);
        if (is_accepted(h)) begin
            exp_hdr_q[lane].push_back(reply_for(h));
        end
        @(posedge clk);
        i_rx_hdr_valid <= 1'b1;
        i_rx_protocol  <= h.protocol;
        i_rx_source_ip <= h.source_ip;
        i_rx_dest_ip   <= h.dest_ip;
        i_rx_length    <= h.length;
        i_rx_ttl       <= h.ttl;
        n = 0;
        do wait_step(n, "o_rx_hdr_ready"); while (!o_rx_hdr_ready);
        @(posedge clk);
        i_rx_hdr_valid <= 1'b0;
        for (int i = 0; i < int'(h.length); i++) begin
            b = 8'($urandom);
            if (is_accepted(h)) begin
                exp_pay_q[lane].push_back(b);
            end
            if (bp_on && ($urandom % 4 == 0)) begin   // idle gap in the payload
                i_rx_pay_valid <= 1'b0;
                @(posedge clk);
            end
            i_rx_pay_valid <= 1'b1;
            i_rx_pay_data  <= b;
            i_rx_pay_last  <= (i == int'(h.length) - 1);
            n = 0;
            do wait_step(n, "o_rx_pay_ready"); while (!o_rx_pay_ready);
            @(posedge clk);
        end
        i_rx_pay_valid <= 1'b0;
        i_rx_pay_last  <= 1'b0;
    endtask

    task automatic receive_packet();
        int      n;
        int      lane;
        ip_hdr_t exp;
        n = 0;
        do wait_step(n, "a transmit header"); while (!(o_tx_hdr_valid && i_tx_hdr_ready));
        lane = lane_of(o_tx_protocol);
        if (lane < 0 || exp_hdr_q[lane].size() == 0) begin
            abort_run($sformatf("reply with protocol %h was not expected", o_tx_protocol));
        end
        exp = exp_hdr_q[lane].pop_front();
        expect_eq("o_tx_protocol", 32'(exp.protocol), 32'(o_tx_protocol));
        expect_eq("o_tx_source_ip", exp.source_ip, o_tx_source_ip);
        expect_eq("o_tx_dest_ip", exp.dest_ip, o_tx_dest_ip);
        expect_eq("o_tx_length", 32'(exp.length), 32'(o_tx_length));
        expect_eq("o_tx_ttl", 32'(exp.ttl), 32'(o_tx_ttl));
        @(posedge clk);
        for (int i = 0; i < int'(exp.length); i++) begin
            n = 0;
            do begin
                wait_step(n, "a transmit payload beat");
                expect_eq("o_tx_hdr_valid", 32'd0, 32'(o_tx_hdr_valid));   // no interleaving
            end while (!(o_tx_pay_valid && i_tx_pay_ready));
            expect_eq("o_tx_pay_data", 32'(exp_pay_q[lane].pop_front()), 32'(o_tx_pay_data));
            expect_eq("o_tx_pay_last", 32'(i == int'(exp.length) - 1), 32'(o_tx_pay_last));
            @(posedge clk);
        end
    endtask

    task automatic run_traffic();
        int kept;
        kept = 0;
        for (int i = 0; i < num_pkts; i++) begin
            if (is_accepted(pkt[i])) begin
                kept++;
            end
        end
        fork
            for (int i = 0; i < num_pkts; i++) send_packet(pkt[i]);
            for (int i = 0; i < kept; i++) receive_packet();
        join
    endtask

    task automatic fill_random(input int n);
        logic [7:0] proto;
        for (int i = 0; i < n; i++) begin
            case ($urandom % 6)
                0:       proto = PROTO_TCP;
                1:       proto = PROTO_UDP;
                2:       proto = PROTO_ICMP;
                3:       proto = 8'd2;
                4:       proto = 8'($urandom);
                default: proto = PROTO_UDP;
            endcase
            pkt[i] = make_hdr(proto, ($urandom % 8 == 0) ? FOREIGN_IP : LOCAL_IP,
                              $urandom_range(40, 1));
        end
        num_pkts = n;
    endtask

    initial begin
        void'($urandom(22));
        i_rx_hdr_valid = 1'b0;
        i_rx_protocol  = '0;
        i_rx_source_ip = '0;
        i_rx_dest_ip   = '0;
        i_rx_length    = '0;
        i_rx_ttl       = '0;
        i_rx_pay_valid = 1'b0;
        i_rx_pay_data  = '0;
        i_rx_pay_last  = 1'b0;
        for (int c = 0; c <= 15; c++) begin
            @(negedge clk);
            expect_eq("o_rx_hdr_ready", 32'd0, 32'(o_rx_hdr_ready));
            expect_eq("o_tx_hdr_valid", 32'd0, 32'(o_tx_hdr_valid));
            expect_eq("o_tx_pay_valid", 32'd0, 32'(o_tx_pay_valid));
            if (c == 14) begin
                @(posedge clk);
                rst <= 1'b0;
            end
        end

        pkt[0] = make_hdr(PROTO_TCP, LOCAL_IP, 5);
        pkt[1] = make_hdr(PROTO_UDP, LOCAL_IP, 12);
        pkt[2] = make_hdr(PROTO_ICMP, LOCAL_IP, 1);
        num_pkts = 3;
        run_traffic();

        pkt[0] = make_hdr(8'd2, LOCAL_IP, 6);
        pkt[1] = make_hdr(PROTO_TCP, FOREIGN_IP, 9);
        pkt[2] = make_hdr(PROTO_UDP, LOCAL_IP, 7);
        run_traffic();

        fill_random(200);
        run_traffic();

        @(posedge clk);
        bp_on <= 1'b1;
        fill_random(100);
        run_traffic();
        @(posedge clk);
        bp_on <= 1'b0;

        repeat (50) begin
            @(negedge clk);
            expect_eq("o_tx_hdr_valid", 32'd0, 32'(o_tx_hdr_valid));
            expect_eq("o_tx_pay_valid", 32'd0, 32'(o_tx_pay_valid));
        end
        if (pending() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("some accepted packets or bytes never came back");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
common/ntw_pkg.sv
verilog/sync_fifo.sv
ip_demux/ip_demux.sv
proto_lane/proto_lane.sv
ip_arb_mux/ip_arb_mux.sv
verilog/ip_proto_switch.sv
sim/tb_ip_proto_switch.sv

//--- verilog/ip_proto_switch.sv
`timescale 1ns/1ps
`default_nettype none

module ip_proto_switch #(
    parameter logic [31:0] LOCAL_IP  = 32'hac000002,
    parameter int          HDR_DEPTH = 4,
    parameter int          PAY_DEPTH = 64
)(
    input  wire         i_clk,
    input  wire         i_rst,

    input  wire         i_rx_hdr_valid,
    output logic        o_rx_hdr_ready,
    input  wire  [7:0]  i_rx_protocol,
    input  wire  [31:0] i_rx_source_ip,
    input  wire  [31:0] i_rx_dest_ip,
    input  wire  [15:0] i_rx_length,
    input  wire  [7:0]  i_rx_ttl,
    input  wire         i_rx_pay_valid,
    output logic        o_rx_pay_ready,
    input  wire  [7:0]  i_rx_pay_data,
    input  wire         i_rx_pay_last,

    output logic        o_tx_hdr_valid,
    input  wire         i_tx_hdr_ready,
    output logic [7:0]  o_tx_protocol,
    output logic [31:0] o_tx_source_ip,
    output logic [31:0] o_tx_dest_ip,
    output logic [15:0] o_tx_length,
    output logic [7:0]  o_tx_ttl,
    output logic        o_tx_pay_valid,
    input  wire         i_tx_pay_ready,
    output logic [7:0]  o_tx_pay_data,
    output logic        o_tx_pay_last
);

    import ntw_pkg::*;

    // demux to lanes
    logic [NUM_LANES-1:0] lane_in_hdr_valid;
    logic [NUM_LANES-1:0] lane_in_hdr_ready;
    logic [7:0]           lane_in_protocol  [NUM_LANES];
    logic [31:0]          lane_in_source_ip [NUM_LANES];
    logic [15:0]          lane_in_length    [NUM_LANES];
    logic [NUM_LANES-1:0] lane_in_pay_valid;
    logic [NUM_LANES-1:0] lane_in_pay_ready;
    logic [7:0]           lane_in_pay_data  [NUM_LANES];
    logic [NUM_LANES-1:0] lane_in_pay_last;

    // lanes to mux
    logic [NUM_LANES-1:0] lane_out_hdr_valid;
    logic [NUM_LANES-1:0] lane_out_hdr_ready;
    logic [7:0]           lane_out_protocol  [NUM_LANES];
    logic [31:0]          lane_out_source_ip [NUM_LANES];
    logic [31:0]          lane_out_dest_ip   [NUM_LANES];
    logic [15:0]          lane_out_length    [NUM_LANES];
    logic [7:0]           lane_out_ttl       [NUM_LANES];
    logic [NUM_LANES-1:0] lane_out_pay_valid;
    logic [NUM_LANES-1:0] lane_out_pay_ready;
    logic [7:0]           lane_out_pay_data  [NUM_LANES];
    logic [NUM_LANES-1:0] lane_out_pay_last;

    ip_demux #(
        .LOCAL_IP (LOCAL_IP)
    ) u_ip_demux (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_rx_hdr_valid   (i_rx_hdr_valid),
        .o_rx_hdr_ready   (o_rx_hdr_ready),
        .i_rx_protocol    (i_rx_protocol),
        .i_rx_source_ip   (i_rx_source_ip),
        .i_rx_dest_ip     (i_rx_dest_ip),
        .i_rx_length      (i_rx_length),
        .i_rx_ttl         (i_rx_ttl),
        .i_rx_pay_valid   (i_rx_pay_valid),
        .o_rx_pay_ready   (o_rx_pay_ready),
        .i_rx_pay_data    (i_rx_pay_data),
        .i_rx_pay_last    (i_rx_pay_last),
        .o_lane_hdr_valid (lane_in_hdr_valid),
        .i_lane_hdr_ready (lane_in_hdr_ready),
        .o_lane_protocol  (lane_in_protocol),
        .o_lane_source_ip (lane_in_source_ip),
        .o_lane_length    (lane_in_length),
        .o_lane_pay_valid (lane_in_pay_valid),
        .i_lane_pay_ready (lane_in_pay_ready),
        .o_lane_pay_data  (lane_in_pay_data),
        .o_lane_pay_last  (lane_in_pay_last)
    );

    // one echo lane per protocol, indexed by TCP_IDX, UDP_IDX, ICMP_IDX
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        proto_lane #(
            .LOCAL_IP  (LOCAL_IP),
            .HDR_DEPTH (HDR_DEPTH),
            .PAY_DEPTH (PAY_DEPTH)
        ) u_proto_lane (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_hdr_valid (lane_in_hdr_valid[k]),
            .o_hdr_ready (lane_in_hdr_ready[k]),
            .i_protocol  (lane_in_protocol[k]),
            .i_source_ip (lane_in_source_ip[k]),
            .i_length    (lane_in_length[k]),
            .i_pay_valid (lane_in_pay_valid[k]),
            .o_pay_ready (lane_in_pay_ready[k]),
            .i_pay_data  (lane_in_pay_data[k]),
            .i_pay_last  (lane_in_pay_last[k]),
            .o_hdr_valid (lane_out_hdr_valid[k]),
            .i_hdr_ready (lane_out_hdr_ready[k]),
            .o_protocol  (lane_out_protocol[k]),
            .o_source_ip (lane_out_source_ip[k]),
            .o_dest_ip   (lane_out_dest_ip[k]),
            .o_length    (lane_out_length[k]),
            .o_ttl       (lane_out_ttl[k]),
            .o_pay_valid (lane_out_pay_valid[k]),
            .i_pay_ready (lane_out_pay_ready[k]),
            .o_pay_data  (lane_out_pay_data[k]),
            .o_pay_last  (lane_out_pay_last[k])
        );
    end

    ip_arb_mux u_ip_arb_mux (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_lane_hdr_valid (lane_out_hdr_valid),
        .o_lane_hdr_ready (lane_out_hdr_ready),
        .i_lane_protocol  (lane_out_protocol),
        .i_lane_source_ip (lane_out_source_ip),
        .i_lane_dest_ip   (lane_out_dest_ip),
        .i_lane_length    (lane_out_length),
        .i_lane_ttl       (lane_out_ttl),
        .i_lane_pay_valid (lane_out_pay_valid),
        .o_lane_pay_ready (lane_out_pay_ready),
        .i_lane_pay_data  (lane_out_pay_data),
        .i_lane_pay_last  (lane_out_pay_last),
        .o_tx_hdr_valid   (o_tx_hdr_valid),
        .i_tx_hdr_ready   (i_tx_hdr_ready),
        .o_tx_protocol    (o_tx_protocol),
        .o_tx_source_ip   (o_tx_source_ip),
        .o_tx_dest_ip     (o_tx_dest_ip),
        .o_tx_length      (o_tx_length),
        .o_tx_ttl         (o_tx_ttl),
        .o_tx_pay_valid   (o_tx_pay_valid),
        .i_tx_pay_ready   (i_tx_pay_ready),
        .o_tx_pay_data    (o_tx_pay_data),
        .o_tx_pay_last    (o_tx_pay_last)
    );

endmodule

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
)(
    input  wire    i_clk,
    input  wire    i_rst,

    input  wire    i_wr_valid,
    output logic   o_wr_ready,
    input  wire T  i_wr_data,

    output logic   o_rd_valid,
    input  wire    i_rd_ready,
    output T       o_rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign o_wr_ready = (count != (AW+1)'(DEPTH));
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];   // head entry, first word falls through
    assign do_wr      = i_wr_valid && o_wr_ready;
    assign do_rd      = o_rd_valid && i_rd_ready;

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire
